// ==== Makefile ====
TOP := tb_fetch

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

// ==== design/fetch_macros.svh ====
// width and reset-value macros for the fetch front end
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// core datapath widths
`define PC_WD         64
`define INST_WD       32  // no compressed instructions

// instruction sram port
`define SRAM_DATA_WD  64  // two instructions per read word
`define SRAM_ADDR_WD  32  // byte address, low 3 bits ignored by the memory

// first fetch address after reset
`define PC_RESETVAL   64'h8000_0000

`endif

// ==== design/fetch_pkg.sv ====
// package with vector types for pc, instruction and sram words
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [`PC_WD-1:0]        pc_t;         // instruction address
  typedef logic [`INST_WD-1:0]      inst_t;       // one instruction word

  // inst sram side
  typedef logic [`SRAM_ADDR_WD-1:0] sram_addr_t;  // byte address
  typedef logic [`SRAM_DATA_WD-1:0] sram_data_t;  // one 64-bit read word

endpackage

`default_nettype wire

// ==== design/fetch_top.sv ====
// top-level module connecting pc generator, fetch stage and decode stage
`default_nettype none

module fetch_top (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_es_allowin,
  input  wire fetch_pkg::sram_data_t i_inst_sram_rdata,
  output logic                       o_inst_sram_ren,
  output fetch_pkg::sram_addr_t      o_inst_sram_addr,
  output logic                       o_ds_to_es_valid,
  output fetch_pkg::pc_t             o_ds_to_es_pc,
  output fetch_pkg::inst_t           o_ds_to_es_inst
);

  import fetch_pkg::*;

  // producer to buffer
  logic  pg_to_fs_valid;
  pc_t   pg_pc;
  logic  fs_allowin;

  // buffer to consumer
  logic  fs_to_ds_valid;
  pc_t   fs_pc;
  inst_t fs_inst;
  logic  ds_allowin;

  // branch bus back from decode
  logic  br_taken;
  pc_t   br_target;

  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_allowin     (fs_allowin),
    .i_br_taken       (br_taken),
    .i_br_target      (br_target),
    .o_to_fs_valid    (pg_to_fs_valid),
    .o_pc             (pg_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_pg_valid        (pg_to_fs_valid),
    .i_pg_pc           (pg_pc),
    .i_cancel          (br_taken),  // taken jal flushes the slot behind it
    .i_ds_allowin      (ds_allowin),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_allowin      (fs_allowin),
    .o_fs_valid        (fs_to_ds_valid),
    .o_fs_pc           (fs_pc),
    .o_fs_inst         (fs_inst)
  );

  id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_valid       (fs_to_ds_valid),
    .i_fs_pc          (fs_pc),
    .i_fs_inst        (fs_inst),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (ds_allowin),
    .o_br_taken       (br_taken),
    .o_br_target      (br_target),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_pc    (o_ds_to_es_pc),
    .o_ds_to_es_inst  (o_ds_to_es_inst)
  );

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
// decode stage module with JAL detection, target adder and the branch bus
`default_nettype none

`include "fetch_macros.svh"

module id_stage (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_fs_valid,
  input  wire fetch_pkg::pc_t        i_fs_pc,
  input  wire fetch_pkg::inst_t      i_fs_inst,
  input  wire                        i_es_allowin,
  output logic                       o_ds_allowin,
  output logic                       o_br_taken,
  output fetch_pkg::pc_t             o_br_target,
  output logic                       o_ds_to_es_valid,
  output fetch_pkg::pc_t             o_ds_to_es_pc,
  output fetch_pkg::inst_t           o_ds_to_es_inst
);

  import fetch_pkg::*;

  localparam logic [6:0] opcode_jal = 7'b110_1111;

  logic  ds_valid;
  logic  ds_allowin;
  pc_t   ds_pc;
  inst_t ds_inst;
  logic  is_jal;
  pc_t   jal_imm;   // sign-extended j-type offset

  assign ds_allowin = !ds_valid || i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  assign is_jal = (ds_inst[6:0] == opcode_jal);

  // imm[20|10:1|11|19:12] lives in inst[31:12], bit 0 is always zero
  assign jal_imm = {{(`PC_WD-21){ds_inst[31]}},
                    ds_inst[31],
                    ds_inst[19:12],
                    ds_inst[20],
                    ds_inst[30:21],
                    1'b0};

  // redirect only on the edge where the jal actually leaves decode
  assign o_br_taken  = ds_valid && is_jal && i_es_allowin;
  assign o_br_target = ds_pc + jal_imm;

  assign o_ds_allowin     = ds_allowin;
  assign o_ds_to_es_valid = ds_valid;
  assign o_ds_to_es_pc    = ds_pc;
  assign o_ds_to_es_inst  = ds_inst;

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
// fetch stage module with the slot register, allowin, cancel and half-word select
`default_nettype none

`include "fetch_macros.svh"

module if_stage (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_pg_valid,
  input  wire fetch_pkg::pc_t        i_pg_pc,
  input  wire                        i_cancel,
  input  wire                        i_ds_allowin,
  input  wire fetch_pkg::sram_data_t i_inst_sram_rdata,
  output logic                       o_fs_allowin,
  output logic                       o_fs_valid,
  output fetch_pkg::pc_t             o_fs_pc,
  output fetch_pkg::inst_t           o_fs_inst
);

  import fetch_pkg::*;

  logic  fs_valid;
  logic  fs_allowin;
  pc_t   fs_pc;
  inst_t inst_lo;
  inst_t inst_hi;

  // empty, or the held slot leaves this cycle (single-cycle stage)
  assign fs_allowin = !fs_valid || i_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= i_pg_valid;  // wrong path behind a taken jal is replaced here
    end
  end

  // pc of the held slot
  always_ff @(posedge i_clk) begin
    if (i_pg_valid && fs_allowin) begin
      fs_pc <= i_pg_pc;
    end
  end

  // sram word stays put until the next read, so this is stable while stalled
  assign inst_lo = i_inst_sram_rdata[`INST_WD-1:0];
  assign inst_hi = i_inst_sram_rdata[`SRAM_DATA_WD-1:`INST_WD];

  assign o_fs_allowin = fs_allowin;
  assign o_fs_valid   = fs_valid && !i_cancel;  // cancelled slot never reaches decode
  assign o_fs_pc      = fs_pc;
  assign o_fs_inst    = fs_pc[2] ? inst_hi : inst_lo;  // pc[2] picks the upper half

endmodule

`default_nettype wire

// ==== design/pc_gen.sv ====
// pre-fetch stage module with the next-pc register and the inst sram read request
`default_nettype none

`include "fetch_macros.svh"

module pc_gen (
  input  wire                        i_clk,
  input  wire                        i_reset,
  input  wire                        i_fs_allowin,
  input  wire                        i_br_taken,
  input  wire fetch_pkg::pc_t        i_br_target,
  output logic                       o_to_fs_valid,
  output fetch_pkg::pc_t             o_pc,
  output logic                       o_inst_sram_ren,
  output fetch_pkg::sram_addr_t      o_inst_sram_addr
);

  import fetch_pkg::*;

  logic pg_valid;   // a fetch slot is on offer
  pc_t  pc_q;       // sequential next pc
  pc_t  fetch_pc;   // pc offered this cycle
  logic pg_go;      // slot moves into if_stage on this edge

  // a jal leaving decode replaces the sequential pc in the same cycle,
  // so the target read goes out right away and costs a single bubble
  assign fetch_pc = i_br_taken ? i_br_target : pc_q;
  assign pg_go    = pg_valid && i_fs_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pg_valid <= 1'b0;
    end else begin
      pg_valid <= 1'b1;  // always has a next pc once out of reset
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= `PC_RESETVAL;
    end else if (pg_go) begin
      pc_q <= fetch_pc + pc_t'(4);
    end
  end

  assign o_to_fs_valid    = pg_valid;
  assign o_pc             = fetch_pc;

  // read only when the slot advances, so the word lines up with the capture
  assign o_inst_sram_ren  = pg_go;
  assign o_inst_sram_addr = fetch_pc[`SRAM_ADDR_WD-1:0];

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/if_stage.sv
design/id_stage.sv
design/fetch_top.sv
test/fetch_assertions.sv
test/tb_fetch.sv

// ==== test/fetch_assertions.sv ====
// concurrent checks on one pipeline slot, bound into the fetch and decode stages
`default_nettype none

module fetch_assertions (
  input wire                 i_clk,
  input wire                 i_reset,
  input wire                 i_in_valid,        // upstream offers an item
  input wire                 i_out_valid,       // slot holds an item
  input wire                 i_out_allowin,     // downstream takes it
  input wire fetch_pkg::pc_t i_out_pc,
  input wire                 i_redirect,
  input wire                 i_after_redirect   // slot state one cycle after a redirect
);

  // stalled item stays put with the same pc
  hold_while_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
    i_out_valid && !i_out_allowin |=> i_out_valid && $stable(i_out_pc))
    else $error("stalled slot was dropped or changed while downstream held off");

  empty_after_reset: assert property (@(posedge i_clk)
    i_reset |=> !i_out_valid)
    else $error("slot valid right after reset");

  // an empty slot only fills from an offer
  no_fill_without_offer: assert property (@(posedge i_clk) disable iff (i_reset)
    !i_out_valid && !i_in_valid |=> !i_out_valid)
    else $error("slot became valid with nothing offered");

  slot_after_redirect: assert property (@(posedge i_clk) disable iff (i_reset)
    i_redirect |=> i_after_redirect)
    else $error("slot in the wrong state on the cycle after a redirect");

endmodule

// fetch slot picks up the branch target on the cancel edge
bind if_stage fetch_assertions u_fs_checks (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_in_valid       (i_pg_valid),
  .i_out_valid      (fs_valid),
  .i_out_allowin    (i_ds_allowin),
  .i_out_pc         (fs_pc),
  .i_redirect       (i_cancel),
  .i_after_redirect (fs_valid)
);

// decode slot stays empty behind a taken jal
bind id_stage fetch_assertions u_ds_checks (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_in_valid       (i_fs_valid),
  .i_out_valid      (ds_valid),
  .i_out_allowin    (i_es_allowin),
  .i_out_pc         (ds_pc),
  .i_redirect       (o_br_taken),
  .i_after_redirect (!ds_valid)
);

`default_nettype wire

// ==== test/fetch_stim.txt ====
// 0x00..0x1f: memory image, one 64-bit word per line from 0x80000000, lower half = lower pc
// 0x20: number of expected outputs, then one output per line with columns pc inst
@00
0040009300000093
0340006F00800093
0140009301000093
01C0009301800093
0240009302000093
02C0009303C0006F
0340009303000093
03C0009303800093
FDDFF06F04000093
04C0009304800093
0540009305000093
05C0009305800093
0640009306000093
06C000930000006F
@20
000000000000000D
0000000080000000 00000093
0000000080000004 00400093
0000000080000008 00800093
000000008000000C 0340006F
0000000080000040 04000093
0000000080000044 FDDFF06F
0000000080000020 02000093
0000000080000024 02400093
0000000080000028 03C0006F
0000000080000064 06400093
0000000080000068 0000006F
0000000080000068 0000006F
0000000080000068 0000006F

// ==== test/tb_fetch.sv ====
// testbench for fetch_top with sram model, stim trace, back-pressure phase and watchdog
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch;

  import fetch_pkg::*;

  localparam int clk_half     = 2;
  localparam int reset_cycles = 3;
  localparam int image_words  = 32;  // memory image at stim[0..31]
  localparam int trace_base   = 32;  // count, then pc and inst per output
  localparam int stim_depth   = 64;
  localparam sram_addr_t sram_base = sram_addr_t'(`PC_RESETVAL);

  logic       i_clk;
  logic       i_reset;
  logic       i_es_allowin;
  sram_data_t i_inst_sram_rdata;
  logic       o_inst_sram_ren;
  sram_addr_t o_inst_sram_addr;
  logic       o_ds_to_es_valid;
  pc_t        o_ds_to_es_pc;
  inst_t      o_ds_to_es_inst;

  sram_data_t  stim [0:stim_depth-1];
  int          exp_count;
  logic        stim_ready  = 1'b0;
  logic [31:0] lfsr_state  = 32'h4e27c62b;

  fetch_top u_dut (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_es_allowin      (i_es_allowin),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_pc     (o_ds_to_es_pc),
    .o_ds_to_es_inst   (o_ds_to_es_inst)
  );

  initial begin
    i_clk = 1'b0;
    forever #clk_half i_clk = ~i_clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // background for words the image does not define
  function automatic sram_data_t fill_word(input sram_addr_t addr);
    return {addr ^ 32'h5a5a_5a5a, ~addr};
  endfunction

  function automatic sram_data_t sram_word(input sram_addr_t addr);
    sram_addr_t offset;
    int         idx;
    offset = {addr[`SRAM_ADDR_WD-1:3], 3'b000} - sram_base;
    idx    = int'(offset >> 3);
    if (offset < sram_addr_t'(image_words * 8)) begin
      return stim[idx];
    end
    return fill_word({addr[`SRAM_ADDR_WD-1:3], 3'b000});
  endfunction

  task automatic check_pc(input string test_name, input pc_t expected, input pc_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s pc expected %h actual %h", test_name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "pc compare failed");
    end
  endtask

  task automatic check_inst(input string test_name, input inst_t expected, input inst_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s inst expected %h actual %h", test_name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "instruction compare failed");
    end
  endtask

  task automatic check_addr(input string test_name, input sram_addr_t expected,
                            input sram_addr_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s sram addr expected %h actual %h", test_name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "sram address compare failed");
    end
  endtask

  task automatic load_stim();
    for (int i = 0; i < image_words; i++) begin
      stim[i] = fill_word(sram_base + sram_addr_t'(i * 8));
    end
    $readmemh("test/fetch_stim.txt", stim);
    exp_count = int'(stim[trace_base][31:0]);
    if (exp_count < 1 || trace_base + 2 * exp_count >= stim_depth) begin
      $display("stim file does not hold a usable trace length");
      $display("STATUS: FAIL");
      $fatal(1, "bad stim file");
    end
    stim_ready = 1'b1;
  endtask

  // called at time 0 or just after a rising edge
  task automatic apply_reset();
    i_reset = 1'b1;
    repeat (reset_cycles) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
  endtask

  // one pass over the expected trace, sampled at the falling edge
  task automatic run_trace(input string name, input logic stall);
    int         n_seen;
    logic       first_rd;
    logic       accept;
    logic       rd_req;
    sram_addr_t rd_addr;
    string      test_name;
    apply_reset();
    i_es_allowin = stall ? next_rand_bit() : 1'b1;
    n_seen       = 0;
    first_rd     = 1'b1;
    while (n_seen < exp_count) begin
      @(negedge i_clk);
      accept  = o_ds_to_es_valid && i_es_allowin;
      rd_req  = o_inst_sram_ren;
      rd_addr = o_inst_sram_addr;
      if (rd_req && first_rd) begin
        check_addr({name, "_first_read"}, sram_base, rd_addr);
        first_rd = 1'b0;
      end
      if (accept) begin
        test_name = $sformatf("%s[%0d]", name, n_seen);
        check_pc(test_name, stim[trace_base + 1 + 2 * n_seen], o_ds_to_es_pc);
        check_inst(test_name, stim[trace_base + 2 + 2 * n_seen][`INST_WD-1:0],
                   o_ds_to_es_inst);
        n_seen++;
      end
      @(posedge i_clk);
      #1;
      if (rd_req) begin
        i_inst_sram_rdata = sram_word(rd_addr);  // word shows up one cycle after ren
      end
      i_es_allowin = stall ? next_rand_bit() : 1'b1;
    end
  endtask

  initial begin : watchdog
    int limit_cycles;
    wait (stim_ready);
    limit_cycles = 2 * (exp_count * 20 + reset_cycles + 2);  // both passes
    repeat (limit_cycles) @(posedge i_clk);
    $display("timeout, the expected trace did not complete within %0d cycles", limit_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    i_reset           = 1'b1;
    i_es_allowin      = 1'b0;
    i_inst_sram_rdata = '0;
    load_stim();
    run_trace("seq_run", 1'b0);
    run_trace("stall_run", 1'b1);  // same trace under random back-pressure
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
